//--- Makefile
# Verilator flow for the dual-clock FIFO subsystem
#   make lint   lint the RTL
#   make sim    build and run the testbench, fails unless the log shows a pass
#   make clean  remove build products

TOP := tb_fifo_cdc
RTL := $(shell grep '^source/' files.f)
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module fifo_cdc_top $(RTL)

obj_dir/V$(TOP): files.f $(shell cat files.f)
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation completed successfully" $(LOG); then \
		echo "sim: passed"; \
	else \
		echo "sim: no pass line in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
source/fifo_pkg.sv
source/gray_ptr_sync.sv
source/fifo_memory_dp.sv
source/fifo_async.sv
source/fifo_cdc_top.sv
test/tb_fifo_cdc.sv

//--- source/fifo_async.sv
/*
 * dual-clock FIFO core
 * wrap-bit pointers crossed in Gray code, full/empty/prog_full flags,
 * per-side occupancy counts and a read-valid strobe
 */

module fifo_async #(
   parameter int DW        = fifo_pkg::DATA_W,         // word width
   parameter int DEPTH     = fifo_pkg::FIFO_DEPTH,     // entries, power of two
   parameter int PROG_FULL = fifo_pkg::PROG_FULL_LVL   // prog_full threshold
) (
   input  logic                   nreset,    // async, active low, both domains
   // write domain
   input  logic                   wr_clk,
   input  logic                   wr_en,     // dropped while full
   input  logic [DW-1:0]          din,
   output logic                   full,
   output logic                   prog_full,
   output logic [$clog2(DEPTH):0] wr_count,  // occupancy seen from write side
   // read domain
   input  logic                   rd_clk,
   input  logic                   rd_en,     // ignored while empty
   output logic [DW-1:0]          dout,
   output logic                   rd_valid,  // dout holds the word of a read
   output logic                   empty,
   output logic [$clog2(DEPTH):0] rd_count   // occupancy seen from read side
);

   localparam int AW = $clog2(DEPTH);   // address bits, pointers are AW+1

   localparam logic [AW:0] PTR_INC = (AW+1)'(1);
   localparam logic [AW:0] PF_LVL  = (AW+1)'(PROG_FULL);

   logic [AW:0] wr_ptr;        // binary, extra msb for wraparound
   logic [AW:0] wr_ptr_nxt;
   logic [AW:0] rd_ptr;
   logic [AW:0] rd_ptr_nxt;
   logic [AW:0] wr_ptr_sync;   // write pointer as seen in rd_clk
   logic [AW:0] rd_ptr_sync;   // read pointer as seen in wr_clk
   logic        wr_push;       // accepted write
   logic        rd_pop;        // accepted read

   // ##########################################################
   // write side
   // ##########################################################

   assign wr_push    = wr_en & ~full;
   assign wr_ptr_nxt = wr_push ? wr_ptr + PTR_INC : wr_ptr;

   always_ff @(posedge wr_clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
      end else begin
         wr_ptr <= wr_ptr_nxt;
      end
   end

   // same address bits, opposite wrap bit -> writer is one lap ahead
   assign full = (wr_ptr[AW-1:0] == rd_ptr_sync[AW-1:0]) &
                 (wr_ptr[AW] != rd_ptr_sync[AW]);

   assign wr_count  = wr_ptr - rd_ptr_sync;   // modulo 2*DEPTH, never above DEPTH
   assign prog_full = (wr_count >= PF_LVL);

   // next pointer goes in, so the gray flop moves on the same edge as wr_ptr
   gray_ptr_sync #(
      .PW (AW + 1)
   ) wr_ptr_cdc (
      .nreset  (nreset),
      .src_clk (wr_clk),
      .src_ptr (wr_ptr_nxt),
      .dst_clk (rd_clk),
      .dst_ptr (wr_ptr_sync)
   );

   // ##########################################################
   // read side
   // ##########################################################

   assign rd_pop     = rd_en & ~empty;
   assign rd_ptr_nxt = rd_pop ? rd_ptr + PTR_INC : rd_ptr;

   always_ff @(posedge rd_clk or negedge nreset) begin
      if (!nreset) begin
         rd_ptr   <= '0;
         rd_valid <= 1'b0;
      end else begin
         rd_ptr   <= rd_ptr_nxt;
         rd_valid <= rd_pop;   // lines up with the memory output register
      end
   end

   assign empty    = (rd_ptr == wr_ptr_sync);   // all bits equal incl wrap
   assign rd_count = wr_ptr_sync - rd_ptr;

   // read pointer back into wr_clk for full and wr_count
   gray_ptr_sync #(
      .PW (AW + 1)
   ) rd_ptr_cdc (
      .nreset  (nreset),
      .src_clk (rd_clk),
      .src_ptr (rd_ptr_nxt),
      .dst_clk (wr_clk),
      .dst_ptr (rd_ptr_sync)
   );

   // ##########################################################
   // storage
   // ##########################################################

   // enables are the qualified ones, a dropped write never lands
   fifo_memory_dp #(
      .DW (DW),
      .AW (AW)
   ) fifo_mem (
      .wr_clk  (wr_clk),
      .wr_en   (wr_push),
      .wr_addr (wr_ptr[AW-1:0]),
      .wr_din  (din),
      .rd_clk  (rd_clk),
      .rd_en   (rd_pop),
      .rd_addr (rd_ptr[AW-1:0]),
      .rd_dout (dout)
   );

endmodule

//--- source/fifo_cdc_top.sv
/*
 * dual-clock FIFO subsystem top level
 * sets the FIFO geometry and brings the core out to loose ports
 */

module fifo_cdc_top (
   input  logic             nreset,     // async, active low

   // ##########################################################
   // write domain
   // ##########################################################
   input  logic             wr_clk,
   input  logic             wr_en,
   input  fifo_pkg::data_t  din,
   output logic             full,
   output logic             prog_full,
   output fifo_pkg::count_t wr_count,

   // ##########################################################
   // read domain
   // ##########################################################
   input  logic             rd_clk,
   input  logic             rd_en,
   output fifo_pkg::data_t  dout,
   output logic             rd_valid,
   output logic             empty,
   output fifo_pkg::count_t rd_count
);

   import fifo_pkg::*;

   // geometry comes from the package defaults
   fifo_async #(
      .DW        (DATA_W),
      .DEPTH     (FIFO_DEPTH),
      .PROG_FULL (PROG_FULL_LVL)
   ) fifo0 (
      .nreset    (nreset),
      // write side
      .wr_clk    (wr_clk),
      .wr_en     (wr_en),
      .din       (din),
      .full      (full),
      .prog_full (prog_full),
      .wr_count  (wr_count),
      // read side
      .rd_clk    (rd_clk),
      .rd_en     (rd_en),
      .dout      (dout),
      .rd_valid  (rd_valid),
      .empty     (empty),
      .rd_count  (rd_count)
   );

endmodule

//--- source/fifo_memory_dp.sv
/*
 * dual-ported FIFO storage
 * write port on wr_clk, registered read port on rd_clk
 */

module fifo_memory_dp #(
   parameter int DW = fifo_pkg::DATA_W,               // word width
   parameter int AW = $clog2(fifo_pkg::FIFO_DEPTH)    // address width
) (
   // write port
   input  logic          wr_clk,
   input  logic          wr_en,
   input  logic [AW-1:0] wr_addr,
   input  logic [DW-1:0] wr_din,
   // read port
   input  logic          rd_clk,
   input  logic          rd_en,
   input  logic [AW-1:0] rd_addr,
   output logic [DW-1:0] rd_dout
);

   // ##########################################################
   // storage array
   // ##########################################################

   logic [DW-1:0] mem [2**AW];   // plain register array

   // full word writes only
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_din;
      end
   end

   // ##########################################################
   // read port
   // ##########################################################

   // output register loads on a read, holds the last word otherwise
   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         rd_dout <= mem[rd_addr];
      end
   end

endmodule

//--- source/fifo_pkg.sv
/*
 * dual-clock FIFO shared definitions
 * default widths, depth, prog_full threshold and the word/count types
 */

package fifo_pkg;

   // ##########################################################
   // default geometry
   // ##########################################################

   parameter int DATA_W        = 16;   // data word width
   parameter int FIFO_DEPTH    = 16;   // entries, power of two only
   parameter int PROG_FULL_LVL = 12;   // prog_full at or above this occupancy

   // pointer/count width, one wrap bit on top of the address
   // so that a completely full FIFO can still be told apart from empty
   parameter int CNT_W = $clog2(FIFO_DEPTH) + 1;

   // ##########################################################
   // types
   // ##########################################################

   typedef logic [DATA_W-1:0] data_t;   // one payload word
   typedef logic [CNT_W-1:0]  count_t;  // occupancy or pointer, 0..FIFO_DEPTH

endpackage

//--- source/gray_ptr_sync.sv
/*
 * pointer crossing between two clock domains
 * binary -> Gray in src_clk, two flops in dst_clk, Gray -> binary
 */

module gray_ptr_sync #(
   parameter int PW = $clog2(fifo_pkg::FIFO_DEPTH) + 1   // pointer width incl wrap bit
) (
   input  logic          nreset,    // async, active low
   input  logic          src_clk,
   input  logic [PW-1:0] src_ptr,   // binary, source domain
   input  logic          dst_clk,
   output logic [PW-1:0] dst_ptr    // binary, destination domain
);

   logic [PW-1:0] src_gray;    // launched from a flop, never from logic
   logic [PW-1:0] meta_gray;   // first stage, may go metastable
   logic [PW-1:0] sync_gray;   // second stage, safe to use

   // gray back to binary, each bit is xor of all gray bits above it
   function automatic logic [PW-1:0] gray2bin(input logic [PW-1:0] g);
      logic [PW-1:0] b;
      b[PW-1] = g[PW-1];
      for (int i = PW - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // source side register, one bit changes per pointer step
   always_ff @(posedge src_clk or negedge nreset) begin
      if (!nreset) begin
         src_gray <= '0;
      end else begin
         src_gray <= src_ptr ^ (src_ptr >> 1);   // bin2gray
      end
   end

   // two flop synchronizer in the destination clock
   always_ff @(posedge dst_clk or negedge nreset) begin
      if (!nreset) begin
         meta_gray <= '0;
         sync_gray <= '0;
      end else begin
         meta_gray <= src_gray;
         sync_gray <= meta_gray;
      end
   end

   assign dst_ptr = gray2bin(sync_gray);   // comb decode after last stage

endmodule

//--- test/fifo_vectors.txt
// one hex word per line: digit 1 phase, digit 2 op (1 write, 2 read, 3 settle, 0 end)
// digits 3 to 6 the data word, don't care for read and settle
// phase 1, mixed traffic for ordering
111001
111002
111003
120000
111004
120000
120000
111005
111006
120000
120000
120000
130000
// phase 2, fill to full, the last writes get dropped
212001
212002
212003
212004
212005
212006
212007
212008
212009
21200a
21200b
21200c
21200d
21200e
21200f
212010
212011
212012
230000
// phase 3, prog_full at occupancy 13, 12 and 11
320000
320000
320000
330000
320000
330000
320000
330000
// phase 4, drain past empty
420000
420000
420000
420000
420000
420000
420000
420000
420000
420000
420000
420000
420000
430000
// phase 5, counts after small bursts
515001
515002
515003
530000
520000
530000
000000

//--- test/tb_fifo_cdc.sv
/*
 * testbench for the dual-clock FIFO subsystem
 * replays the vector file on two drifting clocks and checks against a queue model
 */

module tb_fifo_cdc;

   timeunit 1ns;
   timeprecision 100ps;

   import fifo_pkg::*;

   // ##########################################################
   // vector encoding, one 24 bit word per line
   // ##########################################################

   localparam logic [3:0] OP_END    = 4'h0;
   localparam logic [3:0] OP_WRITE  = 4'h1;
   localparam logic [3:0] OP_READ   = 4'h2;
   localparam logic [3:0] OP_SETTLE = 4'h3;   // idle until both sides agree

   // ##########################################################
   // DUT signals
   // ##########################################################

   logic   wr_clk = 1'b0;
   logic   rd_clk = 1'b0;
   logic   nreset;
   logic   wr_en;
   data_t  din;
   logic   full;
   logic   prog_full;
   count_t wr_count;
   logic   rd_en;
   data_t  dout;
   logic   rd_valid;
   logic   empty;
   count_t rd_count;

   logic [23:0] vec_mem [0:127];   // phase | op | data
   data_t       model_mem [0:255]; // queue model, written by driver, read by monitor

   int push_cnt       = 0;   // accepted writes
   int dropped_writes = 0;
   int reads_accepted = 0;   // driver side, empty was low
   int reads_ignored  = 0;
   int valids_seen    = 0;   // monitor side
   int pop_cnt        = 0;
   int chk_checks     = 0;
   int chk_errs       = 0;
   int mon_checks     = 0;
   int mon_errs       = 0;
   int cycle_limit    = 200; // raised once the vectors are counted
   int cycle_cnt      = 0;

   always #10 wr_clk = ~wr_clk;   // 20 ns
   always #14 rd_clk = ~rd_clk;   // 28 ns, drifts against wr_clk

   fifo_cdc_top dut0 (
      .nreset    (nreset),
      .wr_clk    (wr_clk),
      .wr_en     (wr_en),
      .din       (din),
      .full      (full),
      .prog_full (prog_full),
      .wr_count  (wr_count),
      .rd_clk    (rd_clk),
      .rd_en     (rd_en),
      .dout      (dout),
      .rd_valid  (rd_valid),
      .empty     (empty),
      .rd_count  (rd_count)
   );

   // ##########################################################
   // helpers
   // ##########################################################

   function automatic string phase_name(input logic [3:0] tag);
      case (tag)
         4'h0:    return "reset state";
         4'h1:    return "order";
         4'h2:    return "fill";
         4'h3:    return "threshold";
         4'h4:    return "drain";
         4'h5:    return "counts";
         default: return "unnamed";
      endcase
   endfunction

   task automatic expect_eq(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
      chk_checks++;
      if (act !== exp) begin
         $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, act);
         chk_errs++;
      end
   endtask

   // write inputs change on the falling wr_clk edge, full is stable there
   task automatic drive_write(input data_t d);
      @(negedge wr_clk);
      if (!full) begin
         model_mem[push_cnt[7:0]] = d;
         push_cnt++;
      end else begin
         dropped_writes++;   // must never show up at dout
      end
      wr_en = 1'b1;
      din   = d;
   endtask

   task automatic release_write;
      @(negedge wr_clk);
      wr_en = 1'b0;
   endtask

   task automatic drive_read;
      @(negedge rd_clk);
      if (!empty) begin
         reads_accepted++;
      end else begin
         reads_ignored++;
      end
      rd_en = 1'b1;
   endtask

   task automatic release_read;
      @(negedge rd_clk);
      rd_en = 1'b0;
   endtask

   // crossing takes at most three edges, four of each clock covers it
   task automatic settle_and_check;
      int occ;
      repeat (4) @(negedge wr_clk);
      while (valids_seen < reads_accepted) begin
         @(negedge rd_clk);   // outstanding rd_valid strobes
      end
      repeat (4) @(negedge rd_clk);
      @(negedge wr_clk);
      occ = push_cnt - reads_accepted;
      expect_eq("wr_count", 32'(occ), 32'(wr_count));
      expect_eq("rd_count", 32'(occ), 32'(rd_count));
      expect_eq("full", 32'(occ == FIFO_DEPTH), 32'(full));
      expect_eq("empty", 32'(occ == 0), 32'(empty));
      expect_eq("prog_full", 32'(occ >= PROG_FULL_LVL), 32'(prog_full));
   endtask

   task automatic report_phase(input logic [3:0] tag, input int checks_base,
                               input int errs_base);
      int n_chk;
      int n_err;
      n_chk = chk_checks + mon_checks - checks_base;
      n_err = chk_errs + mon_errs - errs_base;
      $display("phase %0d %-12s %0d checks, %0d errors, %s", tag, phase_name(tag),
               n_chk, n_err, (n_err == 0) ? "ok" : "FAILING");
   endtask

   // ##########################################################
   // read monitor, samples on the falling rd_clk edge
   // ##########################################################

   always @(negedge rd_clk) begin
      if (nreset && rd_valid) begin
         mon_checks++;
         if (valids_seen >= reads_accepted) begin
            $display("rd_valid went high with no accepted read outstanding");
            mon_errs++;
         end else if (pop_cnt >= push_cnt) begin
            $display("rd_valid went high while the model holds no word");
            mon_errs++;
         end else begin
            if (dout !== model_mem[pop_cnt[7:0]]) begin
               $display("MISMATCH dout: expected 0x%0h, got 0x%0h",
                        model_mem[pop_cnt[7:0]], dout);
               mon_errs++;
            end
            pop_cnt++;   // oldest unread word consumed
         end
         valids_seen++;
      end
   end

   // ##########################################################
   // watchdog
   // ##########################################################

   initial begin
      while (cycle_cnt < cycle_limit) begin
         @(posedge wr_clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d wr_clk cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
   end

   // ##########################################################
   // main sequence
   // ##########################################################

   initial begin
      int          vec_count;
      int          checks_base;
      int          errs_base;
      logic [23:0] v;
      logic [3:0]  cur_phase;
      logic [3:0]  nxt_op;
      nreset = 1'b0;
      wr_en  = 1'b0;
      din    = '0;
      rd_en  = 1'b0;
      for (int i = 0; i < 128; i++) begin
         vec_mem[i[6:0]] = '0;   // unused lines read as end
      end
      $readmemh("test/fifo_vectors.txt", vec_mem);
      vec_count = 0;
      while (vec_count < 127 && vec_mem[vec_count[6:0]][19:16] != OP_END) begin
         vec_count++;
      end
      cycle_limit = 10 * vec_count + 200;

      repeat (16) @(posedge wr_clk);
      @(negedge wr_clk);
      nreset = 1'b1;

      // reset state
      cur_phase   = 4'h0;
      checks_base = 0;
      errs_base   = 0;
      @(negedge wr_clk);
      expect_eq("empty", 32'd1, 32'(empty));
      expect_eq("full", 32'd0, 32'(full));
      expect_eq("prog_full", 32'd0, 32'(prog_full));
      expect_eq("rd_valid", 32'd0, 32'(rd_valid));
      expect_eq("wr_count", 32'd0, 32'(wr_count));
      expect_eq("rd_count", 32'd0, 32'(rd_count));

      for (int i = 0; i < vec_count; i++) begin
         v      = vec_mem[i[6:0]];
         nxt_op = vec_mem[(i + 1) & 127][19:16];
         if (v[23:20] != cur_phase) begin
            report_phase(cur_phase, checks_base, errs_base);
            cur_phase   = v[23:20];
            checks_base = chk_checks + mon_checks;
            errs_base   = chk_errs + mon_errs;
         end
         case (v[19:16])
            OP_WRITE: begin
               drive_write(v[15:0]);
               if (nxt_op != OP_WRITE) begin
                  release_write();   // back to back writes keep wr_en high
               end
            end
            OP_READ: begin
               drive_read();
               if (nxt_op != OP_READ) begin
                  release_read();
               end
            end
            OP_SETTLE: settle_and_check();
            default: begin
               $display("vector %0d holds an unknown operation code", i);
               chk_errs++;
            end
         endcase
      end
      report_phase(cur_phase, checks_base, errs_base);

      $display("checks %0d, errors %0d, words read %0d, writes dropped %0d, reads ignored %0d",
               chk_checks + mon_checks, chk_errs + mon_errs, pop_cnt, dropped_writes,
               reads_ignored);
      if (chk_errs + mon_errs == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
